/* list.f */
verilog/vsaIsaPkg.sv
verilog/vsaCtrlPkg.sv
verilog/regFileIf.sv
verilog/aluIf.sv
verilog/vsaRegFile.sv
verilog/vsaAlu.sv
verilog/vsaCore.sv
verilog/vsaTop.sv
sim/tbClock.sv
sim/tbTop.sv

/* Makefile */
# Verilator build and run of the VSA testbench

VERILATOR ?= verilator
TOP       ?= tbTop
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= *** PASSED ***

SOURCES := $(wildcard verilog/*.sv sim/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

# the run passes only when the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* sim/tbTop.sv */
// testbench top: random programs and data memory served to the VSA core,
// instruction-level model, per-instruction checks, final register dump
`timescale 1ns/1ps

module tbTop;

    localparam int numInstr     = 400;  // random phase
    localparam int refreshEvery = 64;   // new random program now and then
    localparam int dumpInstr    = 8;    // SW of R0..R3, twice over
    localparam int instrCycles  = 5;    // fetch to write-back
    localparam int instrTimeout = 12;   // cycles from decode to decode
    localparam int resetTimeout = 40;
    localparam logic [4:0] dumpAddr = 5'h1e;

    // opcode encodings
    localparam logic [2:0] opLw   = 3'd0;
    localparam logic [2:0] opSw   = 3'd1;
    localparam logic [2:0] opBeqz = 3'd2;
    localparam logic [2:0] opAlu  = 3'd3;
    localparam logic [2:0] opAddi = 3'd4;
    localparam logic [2:0] opSubi = 3'd5;  // 6, 7 unused

    logic        clock;
    logic        rstN;
    logic [4:0]  pc;
    logic [11:0] instruction;
    logic [4:0]  dataAddr;
    logic [4:0]  dataIn;
    logic [4:0]  dataOut;
    logic        wr;

    logic [11:0] imem [0:31];   // program, indexed by pc
    logic [4:0]  dmem [0:31];   // data memory seen by the DUT

    // architectural model
    logic [4:0]  modelPc;
    logic [4:0]  modelRegs [0:3];
    logic [4:0]  modelMem [0:31];

    logic [31:0] rngState;
    int          errorCount;
    int          instrCount;
    bit          timedOut;

    tbClock clockGen (
        .clock (clock),
        .rstN  (rstN)
    );

    vsaTop #(
        .resetPc     (5'd0)
    ) UUT (
        .clock       (clock),
        .rstN        (rstN),
        .pc          (pc),
        .instruction (instruction),
        .dataAddr    (dataAddr),
        .dataIn      (dataIn),
        .dataOut     (dataOut),
        .wr          (wr)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // opcode, source1, source2, 5-bit immediate
    function automatic logic [11:0] encodeWord(input logic [2:0] op, input logic [1:0] s1,
                                               input logic [1:0] s2, input logic [4:0] imm);
        return {op, s1, s2, imm};
    endfunction

    function automatic logic [4:0] modelAlu(input logic [2:0] fn, input logic [4:0] x,
                                            input logic [4:0] y);
        logic [4:0] r;
        case (fn)
            3'd0:    r = x + y;             // wraps at 32
            3'd1:    r = x - y;
            3'd2:    r = x & y;
            3'd3:    r = x | y;
            3'd4:    r = x ^ y;
            3'd5:    r = ~x;
            3'd6:    r = {1'b0, x[4:1]};    // logical
            default: r = {x[4], x[4:1]};    // arithmetic, sign kept
        endcase
        return r;
    endfunction

    // next pc plus twice the low four immediate bits
    function automatic logic [4:0] branchTarget(input logic [4:0] at, input logic [4:0] imm);
        logic [4:0] offset;
        offset = {imm[3:0], 1'b0};
        return at + 5'd2 + offset;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("error: %s is 0x%0h, expected 0x%0h at %0t", name, actual, expected,
                     $time);
        end
    endtask

    task automatic writeReg(input logic [1:0] r, input logic [4:0] v);
        if (r != 2'd0)
            modelRegs[r] = v;  // R0 stays zero
    endtask

    // one instruction on the model, from the plain ISA rules
    task automatic modelStep(input logic [11:0] word);
        logic [2:0] op;
        logic [1:0] s1;
        logic [1:0] s2;
        logic [1:0] d;
        logic [2:0] fn;
        logic [4:0] imm;
        logic [4:0] x;
        logic [4:0] y;
        logic [4:0] addr;
        logic [4:0] nextPc;
        op     = word[11:9];
        s1     = word[8:7];
        s2     = word[6:5];
        d      = word[4:3];
        fn     = word[2:0];
        imm    = word[4:0];  // zero-extended
        x      = modelRegs[s1];
        y      = modelRegs[s2];
        addr   = x + imm;
        nextPc = modelPc + 5'd2;
        case (op)
            opLw:   writeReg(s2, modelMem[addr]);
            opSw:   modelMem[addr] = y;
            opBeqz: begin
                if (x == 5'd0)
                    nextPc = branchTarget(modelPc, imm);
            end
            opAlu:  writeReg(d, modelAlu(fn, x, y));
            opAddi: writeReg(s2, x + imm);
            opSubi: writeReg(s2, x - imm);
            default: ;  // unused opcodes only move pc
        endcase
        modelPc = nextPc;
    endtask

    // one clock, then drive instruction and read data, store on wr
    task automatic stepCycle();
        @(posedge clock);
        #1;
        instruction = imem[pc];
        dataIn      = dmem[dataAddr];
        if (wr === 1'b1)
            dmem[dataAddr] = dataOut;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < 32; i++)
            imem[i] = 12'(nextRandom() >> 8);  // any opcode, 6 and 7 included
    endtask

    // every word stores register (addr/2)%4 to dumpAddr, base R0
    task automatic loadDumpProgram();
        for (int a = 0; a < 32; a++)
            imem[a] = encodeWord(opSw, 2'd0, 2'(a >> 1), dumpAddr);
    endtask

    // entered 1 ns into sDecode of the instruction in word
    task automatic runInstruction(input logic [11:0] word);
        int         cycles;
        int         wrCount;
        logic       isStore;
        logic [4:0] storeAddr;
        logic [4:0] storeData;
        isStore   = (word[11:9] == opSw);
        storeAddr = modelRegs[word[8:7]] + word[4:0];
        storeData = modelRegs[word[6:5]];
        checkValue("pc", 32'(pc), 32'(modelPc));
        cycles  = 0;
        wrCount = 0;
        do begin
            stepCycle();
            cycles++;
            if (wr === 1'b1) begin
                wrCount++;
                if (isStore) begin
                    checkValue("dataAddr", 32'(dataAddr), 32'(storeAddr));
                    checkValue("dataOut", 32'(dataOut), 32'(storeData));
                end
            end
        end while (UUT.core.state != vsaCtrlPkg::sDecode && cycles < instrTimeout);
        if (UUT.core.state != vsaCtrlPkg::sDecode) begin
            $display("no decode state reached within %0d cycles after pc 0x%0h",
                     instrTimeout, modelPc);
            errorCount++;
            timedOut = 1'b1;
        end else begin
            checkValue("instruction cycles", 32'(cycles), 32'(instrCycles));
            checkValue("wr", 32'(wrCount), isStore ? 32'd1 : 32'd0);  // SW only, once
            modelStep(word);
        end
    endtask

    initial begin
        logic [11:0] word;
        int          waitCycles;
        rngState    = 32'd35;
        errorCount  = 0;
        instrCount  = 0;
        timedOut    = 1'b0;
        loadProgram();
        for (int i = 0; i < 32; i++) begin
            dmem[i]     = 5'(nextRandom() >> 16);
            modelMem[i] = dmem[i];
        end
        for (int r = 0; r < 4; r++)
            modelRegs[r] = 5'd0;
        modelPc     = 5'd0;
        instruction = imem[0];
        dataIn      = 5'd0;

        stepCycle();  // still in reset
        checkValue("pc", 32'(pc), 32'd0);
        checkValue("wr", 32'(wr), 32'd0);
        waitCycles = 1;
        while (UUT.core.state != vsaCtrlPkg::sDecode && waitCycles < resetTimeout) begin
            stepCycle();
            waitCycles++;
        end
        if (UUT.core.state != vsaCtrlPkg::sDecode) begin
            $display("first instruction never reached decode after reset");
            errorCount++;
            timedOut = 1'b1;
        end

        while (!timedOut && instrCount < numInstr + dumpInstr) begin
            word = imem[modelPc];  // already in IR, next fetch sees any reload
            if (instrCount == numInstr)
                loadDumpProgram();
            else if (instrCount > 0 && instrCount < numInstr &&
                     instrCount % refreshEvery == 0)
                loadProgram();
            runInstruction(word);
            instrCount++;
        end

        $display("summary: %0d instructions, %0d errors", instrCount, errorCount);
        if (errorCount == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* sim/tbClock.sv */
// testbench clock and reset generator
// 20 ns period, rstN held low for 16 rising edges
`timescale 1ns/1ps

module tbClock #(
    parameter int halfPeriod  = 10,  // ns
    parameter int resetCycles = 16
) (
    output logic clock,
    output logic rstN
);

    initial begin
        clock = 1'b0;
        forever #halfPeriod clock = ~clock;
    end

    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clock);
        #1;              // same skew as the other stimulus
        rstN = 1'b1;
    end

endmodule

/* verilog/vsaTop.sv */
// VSA top level: core, register file and ALU on internal buses
// instruction and data memory sit outside on plain ports
`timescale 1ns/1ps

module vsaTop #(
    parameter vsaIsaPkg::addrT resetPc = '0
) (
    input  logic             clock,
    input  logic             rstN,
    output vsaIsaPkg::addrT  pc,           // instruction memory address
    input  vsaIsaPkg::instrT instruction,  // valid by end of fetch
    output vsaIsaPkg::addrT  dataAddr,
    input  vsaIsaPkg::dataT  dataIn,       // valid by end of memory state
    output vsaIsaPkg::dataT  dataOut,
    output logic             wr            // store strobe
);

    regFileIf rfBus ();
    aluIf     aluBus ();

    vsaCore #(
        .resetPc     (resetPc)
    ) core (
        .clock       (clock),
        .rstN        (rstN),
        .pc          (pc),
        .instruction (instruction),
        .dataAddr    (dataAddr),
        .dataIn      (dataIn),
        .dataOut     (dataOut),
        .wr          (wr),
        .rf          (rfBus.core),
        .alu         (aluBus.core)
    );

    vsaRegFile regFile (
        .clock (clock),
        .rstN  (rstN),
        .rf    (rfBus.regs)
    );

    // purely combinational
    vsaAlu alu (
        .alu (aluBus.alu)
    );

endmodule

/* verilog/vsaCore.sv */
// VSA core: five-state sequencer, IR/NPC/A/B/ALU-out/cond/LMD latches,
// opcode decode, operand select, branch decision, memory port drive
`timescale 1ns/1ps

module vsaCore #(
    parameter vsaIsaPkg::addrT resetPc = '0  // first fetch address
) (
    input  logic              clock,
    input  logic              rstN,
    output vsaIsaPkg::addrT   pc,           // instruction address
    input  vsaIsaPkg::instrT  instruction,
    output vsaIsaPkg::addrT   dataAddr,
    input  vsaIsaPkg::dataT   dataIn,
    output vsaIsaPkg::dataT   dataOut,
    output logic              wr,           // data memory write strobe
    regFileIf.core            rf,
    aluIf.core                alu
);

    vsaCtrlPkg::stateT state;
    vsaCtrlPkg::stateT stateNext;

    vsaIsaPkg::instrT ir;
    vsaIsaPkg::addrT  npc;     // pc + 2
    vsaIsaPkg::dataT  a;       // source1 value
    vsaIsaPkg::dataT  b;       // source2 value
    vsaIsaPkg::dataT  aluOut;  // address, result or branch target
    logic             cond;    // taken branch
    vsaIsaPkg::dataT  lmd;     // load data

    // IR fields
    vsaIsaPkg::opcodeT  opcode;
    vsaIsaPkg::functT   funct;
    vsaIsaPkg::regAddrT src1;
    vsaIsaPkg::regAddrT src2;
    vsaIsaPkg::regAddrT dst;
    vsaIsaPkg::dataT    imm;   // zero-extended

    logic memRef;
    logic regRegAlu;
    logic regImmAlu;
    logic branch;
    logic isLoad;

    assign opcode = vsaIsaPkg::opcodeT'(ir[vsaIsaPkg::opcodeHi:vsaIsaPkg::opcodeLo]);
    assign funct  = vsaIsaPkg::functT'(ir[vsaIsaPkg::functHi:vsaIsaPkg::functLo]);
    assign src1   = ir[vsaIsaPkg::src1Hi:vsaIsaPkg::src1Lo];
    assign src2   = ir[vsaIsaPkg::src2Hi:vsaIsaPkg::src2Lo];
    assign dst    = ir[vsaIsaPkg::dstHi:vsaIsaPkg::dstLo];
    assign imm    = vsaIsaPkg::dataT'(ir[vsaIsaPkg::immHi:vsaIsaPkg::immLo]);

    // instruction classes
    assign isLoad    = (opcode == vsaIsaPkg::lw);
    assign memRef    = isLoad || (opcode == vsaIsaPkg::sw);
    assign regRegAlu = (opcode == vsaIsaPkg::aluOp);
    assign regImmAlu = (opcode == vsaIsaPkg::addi) || (opcode == vsaIsaPkg::subi);
    assign branch    = (opcode == vsaIsaPkg::beqz);

    // sequencer, strictly cyclic
    always_comb begin
        case (state)
            vsaCtrlPkg::sFetch:   stateNext = vsaCtrlPkg::sDecode;
            vsaCtrlPkg::sDecode:  stateNext = vsaCtrlPkg::sExecute;
            vsaCtrlPkg::sExecute: stateNext = vsaCtrlPkg::sMemory;
            vsaCtrlPkg::sMemory:  stateNext = vsaCtrlPkg::sWriteBack;
            default:              stateNext = vsaCtrlPkg::sFetch;
        endcase
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN)
            state <= vsaCtrlPkg::sFetch;
        else
            state <= stateNext;
    end

    // ALU op from opcode and function field
    always_comb begin
        case (opcode)
            vsaIsaPkg::lw, vsaIsaPkg::sw, vsaIsaPkg::beqz, vsaIsaPkg::addi:
                alu.op = vsaCtrlPkg::opAdd;   // address, target, ADDI
            vsaIsaPkg::subi:
                alu.op = vsaCtrlPkg::opSub;
            vsaIsaPkg::aluOp: begin
                case (funct)
                    vsaIsaPkg::fAdd: alu.op = vsaCtrlPkg::opAdd;
                    vsaIsaPkg::fSub: alu.op = vsaCtrlPkg::opSub;
                    vsaIsaPkg::fAnd: alu.op = vsaCtrlPkg::opAnd;
                    vsaIsaPkg::fOr:  alu.op = vsaCtrlPkg::opOr;
                    vsaIsaPkg::fXor: alu.op = vsaCtrlPkg::opXor;
                    vsaIsaPkg::fNot: alu.op = vsaCtrlPkg::opNot;
                    vsaIsaPkg::fSrl: alu.op = vsaCtrlPkg::opSrl;
                    default:         alu.op = vsaCtrlPkg::opSra;
                endcase
            end
            default:
                alu.op = vsaCtrlPkg::opPass;  // codes 6, 7
        endcase
    end

    // operand select
    // branch target is NPC + imm[3:0] * 2
    assign alu.opA = branch ? vsaIsaPkg::dataT'(npc) : a;
    always_comb begin
        if (regRegAlu)
            alu.opB = b;
        else if (branch)
            alu.opB = imm << 1;  // top imm bit drops out
        else
            alu.opB = imm;       // LW, SW, ADDI, SUBI
    end

    // per-state latches
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc     <= resetPc;
            npc    <= '0;
            ir     <= '0;
            a      <= '0;
            b      <= '0;
            aluOut <= '0;
            cond   <= 1'b0;
            lmd    <= '0;
        end else begin
            case (state)
                vsaCtrlPkg::sFetch: begin
                    ir  <= instruction;
                    npc <= pc + vsaIsaPkg::addrT'(vsaIsaPkg::pcStep);
                end
                vsaCtrlPkg::sDecode: begin
                    a <= rf.rdData1;
                    b <= rf.rdData2;
                end
                vsaCtrlPkg::sExecute: begin
                    aluOut <= alu.result;
                    cond   <= branch && (a == '0);  // BEQZ tests A only
                end
                vsaCtrlPkg::sMemory: begin
                    if (isLoad)
                        lmd <= dataIn;
                    pc <= cond ? vsaIsaPkg::addrT'(aluOut) : npc;
                end
                default: ;  // write-back goes through rf
            endcase
        end
    end

    // register reads straight from IR fields
    assign rf.rdAddr1 = src1;
    assign rf.rdAddr2 = src2;

    // write-back, R-format to dst, I-format to src2
    assign rf.wrEn   = (state == vsaCtrlPkg::sWriteBack) && (regRegAlu || regImmAlu || isLoad);
    assign rf.wrAddr = regRegAlu ? dst : src2;
    assign rf.wrData = isLoad ? lmd : aluOut;

    // data memory side
    assign dataAddr = vsaIsaPkg::addrT'(aluOut);
    assign dataOut  = b;
    assign wr       = (state == vsaCtrlPkg::sMemory) && memRef && !isLoad;

    // store strobe only in sMemory, the clock right after execute
    assert property (@(posedge clock) disable iff (!rstN)
        wr |-> $past(state) == vsaCtrlPkg::sExecute)
        else $error("wr outside sMemory");

    assert property (@(posedge clock) disable iff (!rstN)
        state inside {vsaCtrlPkg::sFetch, vsaCtrlPkg::sDecode, vsaCtrlPkg::sExecute,
                      vsaCtrlPkg::sMemory, vsaCtrlPkg::sWriteBack})
        else $error("illegal state %0d", state);

    // same source twice means A and B hold the same register value
    assert property (@(posedge clock) disable iff (!rstN)
        (src1 == src2) && state inside {vsaCtrlPkg::sExecute, vsaCtrlPkg::sMemory,
                                        vsaCtrlPkg::sWriteBack} |-> a == b)
        else $error("A/B mismatch for equal source fields");

endmodule

/* verilog/vsaAlu.sv */
// combinational ALU, 5-bit wraparound arithmetic
// add, sub, logic ops, not, one-bit logical and arithmetic right shift
`timescale 1ns/1ps

module vsaAlu (
    aluIf.alu alu
);

    vsaIsaPkg::dataT srlRes;
    vsaIsaPkg::dataT sraRes;

    assign srlRes = alu.opA >> 1;                               // msb fills 0
    assign sraRes = vsaIsaPkg::dataT'($signed(alu.opA) >>> 1);  // msb kept

    always_comb begin
        case (alu.op)
            vsaCtrlPkg::opAdd:
                alu.result = alu.opA + alu.opB;  // carry dropped
            vsaCtrlPkg::opSub:
                alu.result = alu.opA - alu.opB;
            vsaCtrlPkg::opAnd:
                alu.result = alu.opA & alu.opB;
            vsaCtrlPkg::opOr:
                alu.result = alu.opA | alu.opB;
            vsaCtrlPkg::opXor:
                alu.result = alu.opA ^ alu.opB;
            vsaCtrlPkg::opNot:
                alu.result = ~alu.opA;           // opB unused
            vsaCtrlPkg::opSrl:
                alu.result = srlRes;
            vsaCtrlPkg::opSra:
                alu.result = sraRes;
            default:
                alu.result = alu.opA;            // pass, no-op opcodes
        endcase
    end

endmodule

/* verilog/vsaRegFile.sv */
// register file: R1..R3 writable, R0 hard-wired to zero
// two asynchronous read ports, one synchronous write port
`timescale 1ns/1ps

module vsaRegFile (
    input  logic   clock,
    input  logic   rstN,
    regFileIf.regs rf
);

    vsaIsaPkg::dataT regs [1:3];  // no storage behind R0

    // read mux, zero for index 0
    function automatic vsaIsaPkg::dataT readReg(input vsaIsaPkg::regAddrT addr);
        vsaIsaPkg::dataT val;
        if (addr == '0)
            val = '0;
        else
            val = regs[addr];
        return val;
    endfunction

    assign rf.rdData1 = readReg(rf.rdAddr1);
    assign rf.rdData2 = readReg(rf.rdAddr2);

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i <= 3; i++)
                regs[i] <= '0;
        end else if (rf.wrEn && rf.wrAddr != '0) begin  // R0 writes dropped
            regs[rf.wrAddr] <= rf.wrData;
        end
    end

    // R0 must stay zero through any write sequence
    assert property (@(posedge clock) disable iff (!rstN)
        ((rf.rdAddr1 == '0) -> (rf.rdData1 == '0)) &&
        ((rf.rdAddr2 == '0) -> (rf.rdData2 == '0)))
        else $error("R0 read returned nonzero");

endmodule

/* verilog/aluIf.sv */
// ALU bus: operands and op from the core, result back
`timescale 1ns/1ps

interface aluIf;

    vsaIsaPkg::dataT   opA;
    vsaIsaPkg::dataT   opB;
    vsaCtrlPkg::aluOpT op;
    vsaIsaPkg::dataT   result;  // combinational, latched in core

    modport core (
        output opA, opB, op,
        input  result
    );

    modport alu (
        input  opA, opB, op,
        output result
    );

endinterface

/* verilog/regFileIf.sv */
// register file bus: two read ports, one write port
`timescale 1ns/1ps

interface regFileIf;

    vsaIsaPkg::regAddrT rdAddr1;  // source1 field
    vsaIsaPkg::regAddrT rdAddr2;  // source2 field
    vsaIsaPkg::dataT    rdData1;
    vsaIsaPkg::dataT    rdData2;

    logic               wrEn;     // sampled at rising edge
    vsaIsaPkg::regAddrT wrAddr;   // addr 0 ignored by regs
    vsaIsaPkg::dataT    wrData;

    modport core (
        output rdAddr1, rdAddr2, wrEn, wrAddr, wrData,
        input  rdData1, rdData2
    );

    modport regs (
        input  rdAddr1, rdAddr2, wrEn, wrAddr, wrData,
        output rdData1, rdData2
    );

endinterface

/* verilog/vsaCtrlPkg.sv */
// controller micro-architecture definitions
// sequencer states and the ALU operation handed from core to ALU
package vsaCtrlPkg;

    // one pass per instruction, five clocks
    typedef enum logic [2:0] {
        sFetch     = 3'd0,
        sDecode    = 3'd1,
        sExecute   = 3'd2,
        sMemory    = 3'd3,
        sWriteBack = 3'd4
    } stateT;

    // function ops plus pass for unused opcodes
    typedef enum logic [3:0] {
        opAdd, opSub, opAnd, opOr,
        opXor, opNot, opSrl, opSra,
        opPass
    } aluOpT;

endpackage

/* verilog/vsaIsaPkg.sv */
// instruction-set definitions of the VSA 12-bit processor
// widths, opcode and function enums, instruction field positions
package vsaIsaPkg;

    localparam int dataWidth    = 5;   // register and data bus
    localparam int addrWidth    = 5;   // pc and data address
    localparam int instrWidth   = 12;
    localparam int regAddrWidth = 2;   // R0..R3

    localparam int pcStep = 2;         // pc increment per instruction

    typedef logic [dataWidth-1:0]    dataT;
    typedef logic [addrWidth-1:0]    addrT;
    typedef logic [instrWidth-1:0]   instrT;
    typedef logic [regAddrWidth-1:0] regAddrT;

    // codes 6 and 7 left free, executed as no-ops
    typedef enum logic [2:0] {
        lw    = 3'd0,
        sw    = 3'd1,
        beqz  = 3'd2,
        aluOp = 3'd3,   // R-format, function field picks the op
        addi  = 3'd4,
        subi  = 3'd5
    } opcodeT;

    typedef enum logic [2:0] {
        fAdd, fSub, fAnd, fOr, fXor, fNot, fSrl, fSra
    } functT;

    // field positions, msb and lsb
    localparam int opcodeHi = 11, opcodeLo = 9;
    localparam int src1Hi   = 8;  // source1
    localparam int src1Lo   = 7;
    localparam int src2Hi   = 6;  // source2, also I-format dest
    localparam int src2Lo   = 5;
    localparam int dstHi    = 4;  // R-format only
    localparam int dstLo    = 3;
    localparam int functHi  = 2;
    localparam int functLo  = 0;
    localparam int immHi    = 4;  // overlaps dst and funct
    localparam int immLo    = 0;

endpackage
